//--- flist.f
+incdir+include
verilog/eeprom_pkg.sv
verilog/i2c_byte_tx.sv
verilog/i2c_byte_rx.sv
verilog/eeprom_sequencer.sv
verilog/eeprom_ctrl_top.sv
testbench/eeprom_model.sv
testbench/eeprom_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the eeprom controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f flist.f --top-module eeprom_ctrl_tb -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
RUN_STATUS=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

if [ $RUN_STATUS -ne 0 ]; then
    echo "simulation exited with status $RUN_STATUS"
    exit 1
fi

exit 0

//--- testbench/eeprom_ctrl_tb.sv
`include "eeprom_settings.svh"

module eeprom_ctrl_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import eeprom_pkg::*;

    localparam int OP_WR = 0;
    localparam int OP_RD = 1;
    localparam int OP_RD_BUSYWR = 2;   // read with a wr strobe while busy

    typedef struct {
        string        name;
        int           op;
        eeprom_addr_t addr;
        eeprom_byte_t data;
        logic         refuse;
        logic         use_ref;
        eeprom_byte_t exp_rd;
        logic         exp_nack;
        logic         chk_rd;
    } entry_t;

    logic         CLK = 1'b0;
    logic         RESET;
    logic         wr;
    logic         rd;
    eeprom_addr_t addr;
    eeprom_byte_t wr_data;
    eeprom_byte_t rd_data;
    logic         done;
    logic         nack;
    logic         busy;
    logic         scl_pull;
    logic         sda_pull;
    logic         model_pull;
    logic         refuse;
    logic         scl;
    logic         sda;

    entry_t       table_q[$];
    eeprom_byte_t ref_mem [0:`EEPROM_MEM_BYTES-1];
    logic         table_ready = 1'b0;
    int           seed = 32'h0504a4f6;
    longint       limit_ns;

    always #20 CLK = ~CLK;

    // open-drain bus
    assign scl = ~scl_pull;
    assign sda = ~(sda_pull | model_pull);

    eeprom_ctrl_top uut
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wr_data  (wr_data),
        .rd_data  (rd_data),
        .done     (done),
        .nack     (nack),
        .busy     (busy),
        .scl_pull (scl_pull),
        .sda_pull (sda_pull),
        .sda_in   (sda)
    );

    eeprom_model slave
    (
        .scl      (scl),
        .sda      (sda),
        .refuse   (refuse),
        .sda_pull (model_pull)
    );

    function automatic eeprom_byte_t initial_pattern(eeprom_addr_t a);
        return a[7:0] ^ 8'h5A ^ {a[10:8], a[10:8], a[10:9]};
    endfunction

    function automatic void add_entry(string name, int op, eeprom_addr_t a, eeprom_byte_t d,
                                      logic rf, logic use_ref, eeprom_byte_t exp_rd,
                                      logic exp_nack, logic chk_rd);
        entry_t e;
        e.name     = name;
        e.op       = op;
        e.addr     = a;
        e.data     = d;
        e.refuse   = rf;
        e.use_ref  = use_ref;
        e.exp_rd   = exp_rd;
        e.exp_nack = exp_nack;
        e.chk_rd   = chk_rd;
        table_q.push_back(e);
    endfunction

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act)
        begin
            $display("ERROR: %s expected %0h actual %0h", name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic run_entry(entry_t e);
        eeprom_byte_t exp;
        exp = e.use_ref ? ref_mem[e.addr] : e.exp_rd;
        refuse  <= e.refuse;
        addr    <= e.addr;
        wr_data <= e.data;
        wr      <= (e.op == OP_WR);
        rd      <= (e.op != OP_WR);
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
        if (e.op == OP_RD_BUSYWR)
        begin
            do @(posedge CLK); while (!busy);
            wr <= 1'b1;     // must be ignored
            @(posedge CLK);
            wr <= 1'b0;
        end
        do @(posedge CLK); while (!done);
        check_value({e.name, " nack"}, 32'(e.exp_nack), 32'(nack));
        if (e.op != OP_WR && e.chk_rd)
            check_value({e.name, " rd_data"}, 32'(exp), 32'(rd_data));
        if (e.op == OP_WR && !e.exp_nack)
            ref_mem[e.addr] = e.data;
        @(posedge CLK);
        check_value({e.name, " done pulse"}, 32'd0, 32'(done));
        check_value({e.name, " idle busy"}, 32'd0, 32'(busy));
        check_value({e.name, " idle scl_pull"}, 32'd0, 32'(scl_pull));
        check_value({e.name, " idle sda_pull"}, 32'd0, 32'(sda_pull));
    endtask

    initial
    begin
        eeprom_addr_t ra [0:3];
        eeprom_byte_t rdat [0:3];
        RESET   = 1'b1;
        wr      = 1'b0;
        rd      = 1'b0;
        addr    = '0;
        wr_data = '0;
        refuse  = 1'b0;
        for (int i = 0; i < `EEPROM_MEM_BYTES; i++)
            ref_mem[i] = initial_pattern(11'(i));

        add_entry("fresh_rd_123", OP_RD, 11'h123, 8'h00, 1'b0, 1'b1, 8'h00, 1'b0, 1'b1);
        add_entry("fresh_rd_7ff", OP_RD, 11'h7FF, 8'h00, 1'b0, 1'b1, 8'h00, 1'b0, 1'b1);
        // same word address in every block, all written before any is read back
        for (int b = 0; b < 8; b++)
            add_entry($sformatf("blk%0d_wr", b), OP_WR, {3'(b), 8'h3C}, 8'hC0 | 8'(b),
                      1'b0, 1'b0, 8'h00, 1'b0, 1'b0);
        for (int b = 0; b < 8; b++)
            add_entry($sformatf("blk%0d_rd", b), OP_RD, {3'(b), 8'h3C}, 8'h00,
                      1'b0, 1'b0, 8'hC0 | 8'(b), 1'b0, 1'b1);
        for (int k = 0; k < 4; k++)
        begin
            ra[k]   = 11'($random(seed));
            rdat[k] = 8'($random(seed));
            add_entry($sformatf("rand_wr%0d", k), OP_WR, ra[k], rdat[k],
                      1'b0, 1'b0, 8'h00, 1'b0, 1'b0);
        end
        for (int k = 0; k < 4; k++)
            add_entry($sformatf("rand_rd%0d", k), OP_RD, ra[k], 8'h00,
                      1'b0, 1'b1, 8'h00, 1'b0, 1'b1);
        add_entry("refused_wr", OP_WR, 11'h0AA, 8'h11, 1'b1, 1'b0, 8'h00, 1'b1, 1'b0);
        add_entry("after_refused_rd", OP_RD, 11'h0AA, 8'h00, 1'b0, 1'b1, 8'h00, 1'b0, 1'b1);
        add_entry("refused_rd", OP_RD, 11'h0AA, 8'h00, 1'b1, 1'b0, 8'h00, 1'b1, 1'b0);
        add_entry("busy_wr_rd", OP_RD_BUSYWR, 11'h345, 8'hE7, 1'b0, 1'b1, 8'h00, 1'b0, 1'b1);
        add_entry("after_busy_rd", OP_RD, 11'h345, 8'h00, 1'b0, 1'b1, 8'h00, 1'b0, 1'b1);
        table_ready = 1'b1;

        repeat (10) @(posedge CLK);
        RESET <= 1'b0;
        @(posedge CLK);
        check_value("reset scl_pull", 32'd0, 32'(scl_pull));
        check_value("reset sda_pull", 32'd0, 32'(sda_pull));
        check_value("reset rd_data", 32'd0, 32'(rd_data));
        check_value("reset busy", 32'd0, 32'(busy));
        check_value("reset done", 32'd0, 32'(done));
        check_value("reset nack", 32'd0, 32'(nack));

        foreach (table_q[i])
            run_entry(table_q[i]);

        $display("Test completed successfully");
        $finish;
    end

    // each transaction stays well under 60 bit times
    initial
    begin
        wait (table_ready);
        limit_ns = longint'(table_q.size()) * 60 * 4 * `I2C_QUARTER_CLKS * 40 + 20000;
        #(limit_ns);
        $display("watchdog expired, a transaction did not finish");
        $display("Test failed");
        $fatal(1);
    end

endmodule

//--- testbench/eeprom_model.sv
`include "eeprom_settings.svh"

module eeprom_model
(
    input  logic scl,
    input  logic sda,
    input  logic refuse,
    output logic sda_pull
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [7:0]  mem [0:`EEPROM_MEM_BYTES-1];
    logic        scl_q = 1'b1;
    logic        sda_q = 1'b1;
    logic        active = 1'b0;
    logic        first_fall = 1'b0;
    logic        rd_mode = 1'b0;
    logic        rd_next = 1'b0;
    logic        drive = 1'b0;
    logic        ack;
    logic [3:0]  bitcnt = 4'd0;
    logic [1:0]  byte_cnt = 2'd0;
    logic [2:0]  blk = 3'd0;
    logic [10:0] ptr = 11'd0;
    logic [7:0]  shreg = 8'd0;
    logic [7:0]  out = 8'd0;

    assign sda_pull = drive;

    initial
    begin
        for (int i = 0; i < `EEPROM_MEM_BYTES; i++)
        begin
            ptr    = 11'(i);
            mem[i] = ptr[7:0] ^ 8'h5A ^ {ptr[10:8], ptr[10:8], ptr[10:9]};
        end
        ptr = 11'd0;
    end

    // everything the slave does happens when scl falls
    task on_scl_fall;
        if (first_fall)
            first_fall = 1'b0;  // the fall that ends the start
        else if (bitcnt == 4'd7)
        begin
            bitcnt = 4'd8;
            if (rd_mode)
                drive = 1'b0;   // let the master ack or nack
            else
            begin
                ack = !refuse;
                case (byte_cnt)
                    2'd0:
                    begin
                        ack     = ack && (shreg[7:4] == `EEPROM_DEVICE_CODE);
                        blk     = shreg[3:1];
                        rd_next = shreg[0];
                    end
                    2'd1:
                        ptr = {blk, shreg};
                    default:
                        if (ack)
                            mem[ptr] = shreg;
                endcase
                drive = ack;
                if (!ack)
                    active = 1'b0;
            end
        end
        else if (bitcnt == 4'd8)
        begin
            drive  = 1'b0;
            bitcnt = 4'd0;
            if (byte_cnt != 2'd3)
                byte_cnt = byte_cnt + 2'd1;
            if (rd_mode)
                active = 1'b0;  // single byte read, wait for stop
            else if (rd_next)
            begin
                rd_mode = 1'b1;
                out     = mem[ptr];
                drive   = ~out[7];
            end
        end
        else
        begin
            bitcnt = bitcnt + 4'd1;
            if (rd_mode)
            begin
                out   = {out[6:0], 1'b0};
                drive = ~out[7];
            end
        end
    endtask

    always @(scl or sda)
    begin
        if (scl_q === 1'b1 && scl === 1'b1 && sda_q === 1'b1 && sda === 1'b0)
        begin
            active     = 1'b1;  // start or repeated start
            first_fall = 1'b1;
            bitcnt     = 4'd0;
            byte_cnt   = 2'd0;
            rd_mode    = 1'b0;
            rd_next    = 1'b0;
            drive      = 1'b0;
        end
        else if (scl_q === 1'b1 && scl === 1'b1 && sda_q === 1'b0 && sda === 1'b1)
        begin
            active = 1'b0;      // stop
            drive  = 1'b0;
        end
        else if (active && scl_q === 1'b0 && scl === 1'b1)
        begin
            if (!rd_mode && bitcnt < 4'd8)
                shreg = {shreg[6:0], sda};
        end
        else if (active && scl_q === 1'b1 && scl === 1'b0)
            on_scl_fall();
        scl_q = scl;
        sda_q = sda;
    end

endmodule

//--- verilog/eeprom_ctrl_top.sv
module eeprom_ctrl_top
(
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     wr,
    input  logic                     rd,
    input  eeprom_pkg::eeprom_addr_t addr,
    input  eeprom_pkg::eeprom_byte_t wr_data,
    output eeprom_pkg::eeprom_byte_t rd_data,
    output logic                     done,
    output logic                     nack,
    output logic                     busy,
    output logic                     scl_pull,
    output logic                     sda_pull,
    input  logic                     sda_in
);
    import eeprom_pkg::*;

    logic           tx_go;
    tx_cmd_e        tx_cmd;
    eeprom_byte_t   tx_byte;
    logic           tx_done;
    logic           tx_acked;
    i2c_line_t      tx_line;
    logic           rx_go;
    logic           rx_last;
    logic           rx_done;
    eeprom_byte_t   rx_byte;
    i2c_line_t      rx_line;
    i2c_line_t      bus_line;
    eeprom_result_t result;

    eeprom_sequencer u_seq
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wr_data  (wr_data),
        .tx_done  (tx_done),
        .tx_acked (tx_acked),
        .tx_line  (tx_line),
        .rx_done  (rx_done),
        .rx_byte  (rx_byte),
        .rx_line  (rx_line),
        .tx_go    (tx_go),
        .tx_cmd   (tx_cmd),
        .tx_byte  (tx_byte),
        .rx_go    (rx_go),
        .rx_last  (rx_last),
        .bus_line (bus_line),
        .result   (result),
        .done     (done),
        .busy     (busy)
    );

    i2c_byte_tx u_tx
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .go      (tx_go),
        .cmd     (tx_cmd),
        .tx_byte (tx_byte),
        .sda_in  (sda_in),
        .line    (tx_line),
        .done    (tx_done),
        .acked   (tx_acked)
    );

    i2c_byte_rx u_rx
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .go      (rx_go),
        .last    (rx_last),
        .sda_in  (sda_in),
        .line    (rx_line),
        .done    (rx_done),
        .rx_byte (rx_byte)
    );

    assign rd_data  = result.rd_data;
    assign nack     = result.nack;
    assign scl_pull = bus_line.scl_low;
    assign sda_pull = bus_line.sda_low;

endmodule

//--- verilog/eeprom_sequencer.sv
`include "eeprom_settings.svh"

module eeprom_sequencer
(
    input  logic                       CLK,
    input  logic                       RESET,
    input  logic                       wr,
    input  logic                       rd,
    input  eeprom_pkg::eeprom_addr_t   addr,
    input  eeprom_pkg::eeprom_byte_t   wr_data,
    input  logic                       tx_done,
    input  logic                       tx_acked,
    input  eeprom_pkg::i2c_line_t      tx_line,
    input  logic                       rx_done,
    input  eeprom_pkg::eeprom_byte_t   rx_byte,
    input  eeprom_pkg::i2c_line_t      rx_line,
    output logic                       tx_go,
    output eeprom_pkg::tx_cmd_e        tx_cmd,
    output eeprom_pkg::eeprom_byte_t   tx_byte,
    output logic                       rx_go,
    output logic                       rx_last,
    output eeprom_pkg::i2c_line_t      bus_line,
    output eeprom_pkg::eeprom_result_t result,
    output logic                       done,
    output logic                       busy
);
    import eeprom_pkg::*;

    seq_state_e   state;
    logic         is_read;
    eeprom_addr_t req_addr;
    eeprom_byte_t req_data;
    logic         rx_sel;   // rx engine owns the bus

    // device code, block bits, direction
    function automatic eeprom_byte_t ctrl_byte(eeprom_addr_t a, logic rd_bit);
        return {`EEPROM_DEVICE_CODE, a[`EEPROM_ADDR_BITS-1:8], rd_bit};
    endfunction

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= S_IDLE;
            is_read <= 1'b0;
            tx_go   <= 1'b0;
            tx_cmd  <= TX_START;
            rx_go   <= 1'b0;
            rx_last <= 1'b0;
            result  <= '0;
            done    <= 1'b0;
            busy    <= 1'b0;
        end
        else
        begin
            tx_go <= 1'b0;
            rx_go <= 1'b0;
            done  <= 1'b0;
            case (state)
                S_IDLE:
                    if (wr || rd)
                    begin
                        is_read <= ~wr;     // write wins if both
                        busy    <= 1'b1;
                        result  <= '0;
                        tx_go   <= 1'b1;
                        tx_cmd  <= TX_START;
                        state   <= S_START;
                    end
                S_START:
                    if (tx_done)
                    begin
                        tx_go  <= 1'b1;
                        tx_cmd <= TX_BYTE;
                        state  <= S_CTRL_W;
                    end
                S_CTRL_W, S_WADDR:
                    if (tx_done)
                    begin
                        tx_go <= 1'b1;
                        if (!tx_acked)
                        begin
                            result.nack <= 1'b1;
                            tx_cmd      <= TX_STOP;
                            state       <= S_STOP;
                        end
                        else if (state == S_CTRL_W)
                        begin
                            tx_cmd <= TX_BYTE;
                            state  <= S_WADDR;
                        end
                        else if (is_read)
                        begin
                            tx_cmd <= TX_START;
                            state  <= S_RESTART;
                        end
                        else
                        begin
                            tx_cmd <= TX_BYTE;
                            state  <= S_DATA;
                        end
                    end
                S_DATA:
                    if (tx_done)
                    begin
                        result.nack <= ~tx_acked;
                        tx_go       <= 1'b1;
                        tx_cmd      <= TX_STOP;
                        state       <= S_STOP;
                    end
                S_RESTART:
                    if (tx_done)
                    begin
                        tx_go  <= 1'b1;
                        tx_cmd <= TX_BYTE;
                        state  <= S_CTRL_R;
                    end
                S_CTRL_R:
                    if (tx_done)
                    begin
                        if (!tx_acked)
                        begin
                            result.nack <= 1'b1;
                            tx_go       <= 1'b1;
                            tx_cmd      <= TX_STOP;
                            state       <= S_STOP;
                        end
                        else
                        begin
                            rx_go   <= 1'b1;
                            rx_last <= 1'b1;    // single byte, master nack
                            state   <= S_READ;
                        end
                    end
                S_READ:
                    if (rx_done)
                    begin
                        result.rd_data <= rx_byte;
                        tx_go          <= 1'b1;
                        tx_cmd         <= TX_STOP;
                        state          <= S_STOP;
                    end
                S_STOP:
                    if (tx_done)
                    begin
                        done  <= 1'b1;
                        busy  <= 1'b0;
                        state <= S_IDLE;
                    end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == S_IDLE && (wr || rd))
        begin
            req_addr <= addr;
            req_data <= wr_data;
        end
    end

    // valid while tx_go is high
    always_comb
    begin
        case (state)
            S_CTRL_W: tx_byte = ctrl_byte(req_addr, 1'b0);
            S_WADDR:  tx_byte = req_addr[7:0];
            S_DATA:   tx_byte = req_data;
            S_CTRL_R: tx_byte = ctrl_byte(req_addr, 1'b1);
            default:  tx_byte = '0;
        endcase
    end

    // switch owner when the engine takes the go, so the held line never glitches
    always_ff @(posedge CLK)
    begin
        if (RESET)
            rx_sel <= 1'b0;
        else if (rx_go)
            rx_sel <= 1'b1;
        else if (tx_go)
            rx_sel <= 1'b0;
    end

    assign bus_line = rx_sel ? rx_line : tx_line;

endmodule

//--- verilog/i2c_byte_rx.sv
`include "eeprom_settings.svh"

module i2c_byte_rx
(
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     go,
    input  logic                     last,
    input  logic                     sda_in,
    output eeprom_pkg::i2c_line_t    line,
    output logic                     done,
    output eeprom_pkg::eeprom_byte_t rx_byte
);
    import eeprom_pkg::*;

    localparam int Q  = `I2C_QUARTER_CLKS;
    localparam int QW = (Q > 1) ? $clog2(Q) : 1;

    logic          active;
    logic          last_q;
    logic [QW-1:0] qcnt;
    logic [1:0]    phase;
    logic [3:0]    bitn;
    logic          q_end;

    assign q_end = (qcnt == QW'(Q - 1));

    function automatic i2c_line_t line_for(logic [1:0] ph, logic [3:0] bn, logic lst);
        i2c_line_t l;
        l.scl_low = (ph == 2'd0) || (ph == 2'd3);
        l.sda_low = (bn == 4'd8) && !lst;   // ack unless last byte
        return l;
    endfunction

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active <= 1'b0;
            last_q <= 1'b0;
            qcnt   <= '0;
            phase  <= 2'd0;
            bitn   <= 4'd0;
            line   <= '0;
            done   <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (!active)
            begin
                if (go)
                begin
                    active <= 1'b1;
                    last_q <= last;
                    qcnt   <= '0;
                    phase  <= 2'd0;
                    bitn   <= 4'd0;
                    line   <= line_for(2'd0, 4'd0, last);
                end
            end
            else if (q_end)
            begin
                qcnt <= '0;
                if (phase != 2'd3)
                begin
                    phase <= phase + 2'd1;
                    line  <= line_for(phase + 2'd1, bitn, last_q);
                end
                else if (bitn != 4'd8)
                begin
                    phase <= 2'd0;
                    bitn  <= bitn + 4'd1;
                    line  <= line_for(2'd0, bitn + 4'd1, last_q);
                end
                else
                begin
                    active <= 1'b0;
                    done   <= 1'b1;
                end
            end
            else
                qcnt <= qcnt + QW'(1);
        end
    end

    // sample each data bit mid scl high
    always_ff @(posedge CLK)
    begin
        if (active && q_end && phase == 2'd1 && bitn != 4'd8)
            rx_byte <= {rx_byte[6:0], sda_in};
    end

endmodule

//--- verilog/i2c_byte_tx.sv
`include "eeprom_settings.svh"

module i2c_byte_tx
(
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     go,
    input  eeprom_pkg::tx_cmd_e      cmd,
    input  eeprom_pkg::eeprom_byte_t tx_byte,
    input  logic                     sda_in,
    output eeprom_pkg::i2c_line_t    line,
    output logic                     done,
    output logic                     acked
);
    import eeprom_pkg::*;

    localparam int Q  = `I2C_QUARTER_CLKS;
    localparam int QW = (Q > 1) ? $clog2(Q) : 1;

    logic          active;
    tx_cmd_e       cmd_q;
    logic [QW-1:0] qcnt;
    logic [1:0]    phase;   // quarter within the bit
    logic [3:0]    bitn;    // 8 is the ack bit
    eeprom_byte_t  shreg;
    logic          q_end;

    assign q_end = (qcnt == QW'(Q - 1));

    // line drive for a given quarter of a symbol
    function automatic i2c_line_t line_for(tx_cmd_e c, logic [1:0] ph, logic [3:0] bn,
                                           logic b);
        i2c_line_t l;
        l.scl_low = (ph == 2'd0) || (ph == 2'd3);
        case (c)
            TX_START:
                l.sda_low = ph[1];  // sda falls while scl high
            TX_STOP:
            begin
                l.scl_low = (ph == 2'd0);
                l.sda_low = ~ph[1]; // sda rises while scl high
            end
            default:
                l.sda_low = (bn == 4'd8) ? 1'b0 : ~b;
        endcase
        return l;
    endfunction

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active <= 1'b0;
            cmd_q  <= TX_START;
            qcnt   <= '0;
            phase  <= 2'd0;
            bitn   <= 4'd0;
            line   <= '0;
            done   <= 1'b0;
            acked  <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (!active)
            begin
                if (go)
                begin
                    active <= 1'b1;
                    cmd_q  <= cmd;
                    qcnt   <= '0;
                    phase  <= 2'd0;
                    bitn   <= 4'd0;
                    line   <= line_for(cmd, 2'd0, 4'd0, tx_byte[7]);
                end
            end
            else if (q_end)
            begin
                qcnt <= '0;
                // middle of scl high in the ninth bit
                if (phase == 2'd1 && cmd_q == TX_BYTE && bitn == 4'd8)
                    acked <= ~sda_in;
                if (phase != 2'd3)
                begin
                    phase <= phase + 2'd1;
                    line  <= line_for(cmd_q, phase + 2'd1, bitn, shreg[7]);
                end
                else if (cmd_q == TX_BYTE && bitn != 4'd8)
                begin
                    phase <= 2'd0;
                    bitn  <= bitn + 4'd1;
                    line  <= line_for(cmd_q, 2'd0, bitn + 4'd1, shreg[6]);
                end
                else
                begin
                    active <= 1'b0;     // line holds its last value
                    done   <= 1'b1;
                end
            end
            else
                qcnt <= qcnt + QW'(1);
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!active && go)
            shreg <= tx_byte;
        else if (active && q_end && phase == 2'd3)
            shreg <= {shreg[6:0], 1'b0};  // msb first
    end

endmodule

//--- verilog/eeprom_pkg.sv
`include "eeprom_settings.svh"

package eeprom_pkg;

    typedef logic [`EEPROM_ADDR_BITS-1:0] eeprom_addr_t;
    typedef logic [7:0] eeprom_byte_t;

    // one engine's drive of the bus, 1 = pull low
    typedef struct packed {
        logic scl_low;
        logic sda_low;
    } i2c_line_t;

    typedef enum logic [1:0] {
        TX_START,   // also used for repeated start
        TX_BYTE,
        TX_STOP
    } tx_cmd_e;

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_W,
        S_WADDR,
        S_DATA,
        S_RESTART,
        S_CTRL_R,
        S_READ,
        S_STOP
    } seq_state_e;

    typedef struct packed {
        logic         nack;
        eeprom_byte_t rd_data;
    } eeprom_result_t;

endpackage

//--- include/eeprom_settings.svh
`ifndef EEPROM_SETTINGS_SVH
`define EEPROM_SETTINGS_SVH

// device type code, upper nibble of every control byte
`define EEPROM_DEVICE_CODE 4'b1010

// CLK cycles per quarter of a serial bit
`define I2C_QUARTER_CLKS 2

// 2K bytes, high three address bits go in the control byte
`define EEPROM_ADDR_BITS 11
`define EEPROM_MEM_BYTES 2048

`endif
